/* source/rx_link_pkg.sv */
// link control codes, field widths, frame state encoding, header and frame record types

package rx_link_pkg;

    //////////////////////////////////////////////////////////////////////////
    // control codes
    //////////////////////////////////////////////////////////////////////////

    // sync word: D5_6 high byte, K28_5 low byte, low K flag only
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;

    // frame start word: K28_2 high byte, K27_7 low byte, both K flags
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;

    // head word, high half first on the link
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'hEB90_E116;

    // sent with both K flags when the far end loses the link
    localparam logic [15:0] LINK_LOSS_WORD = 16'hFFFF;

    //////////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////////

    localparam int RXD_W  = 16;
    localparam int WORD_W = 64;
    localparam int LINE_W = 24;
    localparam int LEN_W  = 16;

    // one state per received word, head takes two
    typedef enum logic [3:0] {
        idle        = 4'd0,
        sync        = 4'd1,
        head        = 4'd2,
        data_type   = 4'd3,
        line_info   = 4'd4,
        data_length = 4'd5,
        recv_data   = 4'd6,
        check_data  = 4'd7,
        frame_end1  = 4'd8,
        frame_end2  = 4'd9
    } rx_state_e;

    // parsed header, 47 bits
    typedef struct packed {
        logic              file_end;
        logic [1:0]        channel_id;
        logic [3:0]        data_type;
        logic [LINE_W-1:0] line_number;
        logic [LEN_W-1:0]  data_length;
    } header_t;

    // one per received frame, 49 bits
    typedef struct packed {
        logic              file_end;
        logic [1:0]        channel_id;
        logic [3:0]        data_type;
        logic [LINE_W-1:0] line_number;
        logic [LEN_W-1:0]  data_length;
        logic              checksum_error;
        logic              overflow;
    } frame_info_t;

endpackage

/* source/rx_frame_decoder.sv */
// frame state machine, head word compare, header field capture and payload count
`timescale 1ns/1ps

module rx_frame_decoder
    import rx_link_pkg::*;
(
    input  logic             i_2711_rx_clk,
    input  logic             i_rst,
    input  logic             i_2711_rkmsb,
    input  logic             i_2711_rklsb,
    input  logic [RXD_W-1:0] i_2711_rxd,
    output rx_state_e        o_state,
    output header_t          o_header,
    output logic             o_payload_stb
);

    rx_state_e        state_q;
    rx_state_e        state_d;
    logic [RXD_W-1:0] prev_rxd;
    logic             head_second;
    logic [LEN_W-2:0] payload_cnt;
    header_t          hdr_q;

    logic sync_word;
    logic start_word;
    logic head_match;
    logic last_payload;

    assign sync_word  = ~i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == {D5_6, K28_5});
    assign start_word = i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == {K28_2, K27_7});
    assign head_match = ({prev_rxd, i_2711_rxd} == FRAME_HEAD_FLAG);

    // length is in bytes, payload is counted in halfwords
    assign last_payload = (payload_cnt == hdr_q.data_length[LEN_W-1:1] - 1'b1);

    //////////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (sync_word) begin
                    state_d = sync;
                end
            end
            sync: begin
                if (start_word) begin
                    state_d = head;
                end
            end
            head: begin
                // first half is only stored, compare on the second
                if (head_second) begin
                    state_d = head_match ? data_type : sync;
                end
            end
            data_type:   state_d = line_info;
            line_info:   state_d = data_length;
            data_length: state_d = recv_data;
            recv_data: begin
                if (last_payload) begin
                    state_d = check_data;
                end
            end
            check_data:  state_d = frame_end1;
            frame_end1:  state_d = frame_end2;
            frame_end2:  state_d = idle;
            default:     state_d = idle;
        endcase
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            state_q     <= idle;
            head_second <= 1'b0;
            payload_cnt <= '0;
        end else begin
            state_q     <= state_d;
            head_second <= (state_q == head) & ~head_second;
            if (state_q == recv_data) begin
                payload_cnt <= payload_cnt + 1'b1;
            end else begin
                payload_cnt <= '0;
            end
        end
    end

    // previous word for the 32-bit head compare
    always_ff @(posedge i_2711_rx_clk) begin
        prev_rxd <= i_2711_rxd;
    end

    //////////////////////////////////////////////////////////////////////////
    // header capture
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        case (state_q)
            data_type: begin
                // bits 15:14 carry the file end flag, only bit 14 is kept
                hdr_q.file_end                   <= i_2711_rxd[14];
                hdr_q.channel_id                 <= i_2711_rxd[13:12];
                hdr_q.data_type                  <= i_2711_rxd[11:8];
                hdr_q.line_number[LINE_W-1:16]   <= i_2711_rxd[7:0];
            end
            line_info: begin
                hdr_q.line_number[15:0] <= i_2711_rxd;
            end
            data_length: begin
                hdr_q.data_length <= i_2711_rxd;
            end
            default: begin
            end
        endcase
    end

    assign o_state       = state_q;
    assign o_header      = hdr_q;
    assign o_payload_stb = (state_q == recv_data);

    // the recv_data exit count is only meaningful for two bytes or more
    a_min_length: assert property (
        @(posedge i_2711_rx_clk) disable iff (i_rst)
        (state_q == data_length) |=> (hdr_q.data_length >= LEN_W'(2))
    );

endmodule

/* source/rx_payload_packer.sv */
// halfword to 64-bit packing, zero padding of the last word and checksum check
`timescale 1ns/1ps

module rx_payload_packer
    import rx_link_pkg::*;
(
    input  logic              i_2711_rx_clk,
    input  logic              i_rst,
    input  logic [RXD_W-1:0]  i_2711_rxd,
    input  rx_state_e         i_state,
    input  logic              i_payload_stb,
    input  logic [LEN_W-1:0]  i_data_length,
    output logic              o_word_stb,
    output logic [WORD_W-1:0] o_word,
    output logic              o_frame_done,
    output logic              o_checksum_error
);

    logic [WORD_W-1:0] shift_q;
    logic [WORD_W-1:0] word_q;
    logic [1:0]        hw_cnt;
    logic [RXD_W-1:0]  sum_q;
    logic              word_stb_q;
    logic              done_q;
    logic              csum_err_q;
    logic              pad_needed;

    // halfwords left over when the byte length is not a multiple of 8
    assign pad_needed = (i_data_length[2:1] != 2'd0);

    //////////////////////////////////////////////////////////////////////////
    // packing
    //////////////////////////////////////////////////////////////////////////

    // new halfword enters at the top, so halfword 0 ends up in bits 15:0
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_payload_stb) begin
            shift_q <= {i_2711_rxd, shift_q[WORD_W-1:RXD_W]};
        end
        if (i_payload_stb && hw_cnt == 2'd3) begin
            word_q <= {i_2711_rxd, shift_q[WORD_W-1:RXD_W]};
        end else if (i_state == check_data) begin
            // move the partial word down and fill the top with zeros
            case (i_data_length[2:1])
                2'd1:    word_q <= {48'h0, shift_q[63:48]};
                2'd2:    word_q <= {32'h0, shift_q[63:32]};
                2'd3:    word_q <= {16'h0, shift_q[63:16]};
                default: word_q <= word_q;
            endcase
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            hw_cnt     <= 2'd0;
            word_stb_q <= 1'b0;
        end else begin
            hw_cnt     <= i_payload_stb ? hw_cnt + 2'd1 : 2'd0;
            word_stb_q <= (i_payload_stb && hw_cnt == 2'd3) ||
                          (i_state == check_data && pad_needed);
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // checksum
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            sum_q      <= '0;
            csum_err_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            case (i_state)
                data_type, line_info, data_length, recv_data: begin
                    sum_q <= sum_q + i_2711_rxd;
                end
                check_data: begin
                    csum_err_q <= (sum_q != i_2711_rxd);
                end
                frame_end1, frame_end2: begin
                end
                default: begin
                    sum_q <= '0;
                end
            endcase
            done_q <= (i_state == frame_end2);
        end
    end

    assign o_word_stb       = word_stb_q;
    assign o_word           = word_q;
    assign o_frame_done     = done_q;
    assign o_checksum_error = csum_err_q;

    // the queue sees at most one word every other cycle
    a_word_spacing: assert property (
        @(posedge i_2711_rx_clk) disable iff (i_rst)
        o_word_stb |=> !o_word_stb
    );

endmodule

/* source/rx_link_monitor.sv */
// link loss detection with a hold-off timer between reports
`timescale 1ns/1ps

module rx_link_monitor
    import rx_link_pkg::*;
#(
    parameter int unsigned LOSS_HOLDOFF = 1000
)
(
    input  logic             i_2711_rx_clk,
    input  logic             i_rst,
    input  logic             i_2711_rkmsb,
    input  logic             i_2711_rklsb,
    input  logic [RXD_W-1:0] i_2711_rxd,
    input  logic             i_link_loss_detect_ena,
    output logic             o_link_loss
);

    logic [23:0] hold_cnt;
    logic        hold_q;
    logic        loss_q;
    logic        loss_word;

    assign loss_word = i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == LINK_LOSS_WORD);

    // hold_q masks detection from the pulse cycle on for LOSS_HOLDOFF cycles
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst || !i_link_loss_detect_ena) begin
            loss_q   <= 1'b0;
            hold_q   <= 1'b0;
            hold_cnt <= '0;
        end else begin
            loss_q <= loss_word & ~hold_q;
            if (loss_word && !hold_q) begin
                hold_q <= 1'b1;
            end else if (hold_cnt == 24'(LOSS_HOLDOFF - 1)) begin
                hold_q <= 1'b0;
            end
            hold_cnt <= hold_q ? hold_cnt + 24'd1 : 24'd0;
        end
    end

    assign o_link_loss = loss_q;

endmodule

/* source/rx_stream_queue.sv */
// synchronous circular queue with a valid/ready read side, any payload type
`timescale 1ns/1ps

module rx_stream_queue
    import rx_link_pkg::*;
#(
    parameter type payload_t = logic [WORD_W-1:0],
    parameter int  DEPTH     = 16
)
(
    input  logic     i_2711_rx_clk,
    input  logic     i_rst,
    input  logic     i_wr_en,
    input  payload_t i_wr_data,
    output logic     o_full,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             rd_en;

    assign rd_en = o_valid & i_ready;

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

    // the writer is expected to gate on o_full
    a_no_write_full: assert property (
        @(posedge i_2711_rx_clk) disable iff (i_rst)
        i_wr_en |-> !o_full
    );

endmodule

/* source/rx_link_top.sv */
// receive lane top: decoder, packer, link monitor, word and record queues
`timescale 1ns/1ps

module rx_link_top
    import rx_link_pkg::*;
#(
    parameter int          WORD_DEPTH   = 64,
    parameter int          RECORD_DEPTH = 8,
    parameter int unsigned LOSS_HOLDOFF = 1000
)
(
    input  logic              i_2711_rx_clk,
    input  logic              i_rst,
    input  logic              i_2711_rkmsb,
    input  logic              i_2711_rklsb,
    input  logic [RXD_W-1:0]  i_2711_rxd,
    input  logic              i_link_loss_detect_ena,

    output logic              o_word_valid,
    input  logic              i_word_ready,
    output logic [WORD_W-1:0] o_word_data,

    output logic              o_info_valid,
    input  logic              i_info_ready,
    output frame_info_t       o_info,

    output logic              o_link_loss
);

    rx_state_e         state;
    header_t           hdr;
    logic              payload_stb;
    logic              word_stb;
    logic [WORD_W-1:0] word;
    logic              frame_done;
    logic              checksum_error;
    logic              word_full;
    logic              info_full;
    logic              overflow_q;
    frame_info_t       record;

    rx_frame_decoder u_decoder (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_2711_rkmsb  (i_2711_rkmsb),
        .i_2711_rklsb  (i_2711_rklsb),
        .i_2711_rxd    (i_2711_rxd),
        .o_state       (state),
        .o_header      (hdr),
        .o_payload_stb (payload_stb)
    );

    rx_payload_packer u_packer (
        .i_2711_rx_clk    (i_2711_rx_clk),
        .i_rst            (i_rst),
        .i_2711_rxd       (i_2711_rxd),
        .i_state          (state),
        .i_payload_stb    (payload_stb),
        .i_data_length    (hdr.data_length),
        .o_word_stb       (word_stb),
        .o_word           (word),
        .o_frame_done     (frame_done),
        .o_checksum_error (checksum_error)
    );

    rx_link_monitor #(
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst                  (i_rst),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .o_link_loss            (o_link_loss)
    );

    ////////////////////////////////////////////////////////////////////////////
    // result assembly
    ////////////////////////////////////////////////////////////////////////////

    // a word lost to a full queue marks the frame, cleared with its record
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            overflow_q <= 1'b0;
        end else if (frame_done) begin
            overflow_q <= 1'b0;
        end else if (word_stb && word_full) begin
            overflow_q <= 1'b1;
        end
    end

    assign record = '{
        file_end:       hdr.file_end,
        channel_id:     hdr.channel_id,
        data_type:      hdr.data_type,
        line_number:    hdr.line_number,
        data_length:    hdr.data_length,
        checksum_error: checksum_error,
        overflow:       overflow_q
    };

    rx_stream_queue #(
        .payload_t (logic [WORD_W-1:0]),
        .DEPTH     (WORD_DEPTH)
    ) u_word_queue (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_wr_en       (word_stb & ~word_full),
        .i_wr_data     (word),
        .o_full        (word_full),
        .o_valid       (o_word_valid),
        .i_ready       (i_word_ready),
        .o_data        (o_word_data)
    );

    rx_stream_queue #(
        .payload_t (frame_info_t),
        .DEPTH     (RECORD_DEPTH)
    ) u_info_queue (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_wr_en       (frame_done & ~info_full),
        .i_wr_data     (record),
        .o_full        (info_full),
        .o_valid       (o_info_valid),
        .i_ready       (i_info_ready),
        .o_data        (o_info)
    );

endmodule

/* verification/rx_link_checker.sv */
// expected output queues, handshake compare, link loss count and final report of the testbench
`timescale 1ns/1ps

module rx_link_checker
    import rx_link_pkg::*;
(
    input logic              i_clk,
    input logic              i_rst,
    input logic              i_word_valid,
    input logic              i_word_ready,
    input logic [WORD_W-1:0] i_word_data,
    input logic              i_info_valid,
    input logic              i_info_ready,
    input frame_info_t       i_info,
    input logic              i_link_loss
);

    logic [WORD_W-1:0] exp_words [$];
    frame_info_t       exp_infos [$];
    int                words_seen  = 0;
    int                infos_seen  = 0;
    int                ovf_infos   = 0;
    int                loss_cycles = 0;
    int                errors      = 0;

    // filled by the frame generator ahead of each frame
    task automatic expect_word(input logic [WORD_W-1:0] exp_word);
        exp_words.push_back(exp_word);
    endtask

    task automatic expect_info(input frame_info_t exp_info);
        exp_infos.push_back(exp_info);
    endtask

    function automatic int pending();
        return exp_words.size() + exp_infos.size();
    endfunction

    function automatic int error_count();
        return errors;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // handshake compare
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        logic [WORD_W-1:0] word;
        frame_info_t       info;
        if (!i_rst && i_word_valid && i_word_ready) begin
            words_seen++;
            if (exp_words.size() == 0) begin
                $display("payload word %h came out while no word was expected", i_word_data);
                errors++;
            end else begin
                word = exp_words.pop_front();
                if (i_word_data !== word) begin
                    $display("** Error: o_word_data = %h, expected %h", i_word_data, word);
                    errors++;
                end
            end
        end
        if (!i_rst && i_info_valid && i_info_ready) begin
            infos_seen++;
            if (i_info.overflow) begin
                ovf_infos++;
            end
            if (exp_infos.size() == 0) begin
                $display("frame record %h came out while no record was expected", i_info);
                errors++;
            end else begin
                info = exp_infos.pop_front();
                if (i_info !== info) begin
                    $display("** Error: o_info = %h, expected %h", i_info, info);
                    errors++;
                end
            end
        end
        // a clean pulse adds exactly one
        if (!i_rst && i_link_loss) begin
            loss_cycles++;
        end
    end

    task automatic check_loss(input int expected);
        if (loss_cycles != expected) begin
            $display("** Error: o_link_loss cycles = %h, expected %h", loss_cycles, expected);
            errors++;
        end
    endtask

    task automatic report(input int timeouts);
        $write("checked %0d words, %0d records (%0d overflow), ",
               words_seen, infos_seen, ovf_infos);
        $display("%0d loss cycles, %0d errors, %0d timeouts",
                 loss_cycles, errors, timeouts);
    endtask

endmodule

/* verification/tb_rx_link.sv */
// testbench top: clock, reset, random frame generator, ready drivers, DUT and checker
`timescale 1ns/1ps

module tb_rx_link
    import rx_link_pkg::*;
();

    localparam int WORD_DEPTH   = 20;
    localparam int RECORD_DEPTH = 8;
    localparam int LOSS_HOLDOFF = 50;
    localparam int TIMEOUT      = 4000;

    logic              rx_clk          = 1'b0;
    logic              rst             = 1'b1;
    logic              rkmsb           = 1'b0;
    logic              rklsb           = 1'b0;
    logic [RXD_W-1:0]  rxd             = '0;
    logic              loss_ena        = 1'b1;
    logic              word_ready      = 1'b0;
    logic              info_ready      = 1'b0;
    logic              word_valid;
    logic [WORD_W-1:0] word_data;
    logic              info_valid;
    frame_info_t       info;
    logic              link_loss;
    integer            seed            = 90847;
    logic              hold_word_ready = 1'b0;
    int                word_room       = 0;
    int                timeouts        = 0;

    always #5 rx_clk = ~rx_clk;

    rx_link_top #(
        .WORD_DEPTH   (WORD_DEPTH),
        .RECORD_DEPTH (RECORD_DEPTH),
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_rx_link_top (
        .i_2711_rx_clk          (rx_clk),
        .i_rst                  (rst),
        .i_2711_rkmsb           (rkmsb),
        .i_2711_rklsb           (rklsb),
        .i_2711_rxd             (rxd),
        .i_link_loss_detect_ena (loss_ena),
        .o_word_valid           (word_valid),
        .i_word_ready           (word_ready),
        .o_word_data            (word_data),
        .o_info_valid           (info_valid),
        .i_info_ready           (info_ready),
        .o_info                 (info),
        .o_link_loss            (link_loss)
    );

    rx_link_checker u_checker (
        .i_clk        (rx_clk),
        .i_rst        (rst),
        .i_word_valid (word_valid),
        .i_word_ready (word_ready),
        .i_word_data  (word_data),
        .i_info_valid (info_valid),
        .i_info_ready (info_ready),
        .i_info       (info),
        .i_link_loss  (link_loss)
    );

    // record ready stays high most of the time so the record queue never fills
    always @(posedge rx_clk) begin
        logic [31:0] r;
        r = $random(seed);
        word_ready <= ~hold_word_ready & (r[0] | r[1]);
        info_ready <= r[2] | r[3] | r[4];
    end

    ////////////////////////////////////////////////////////////////////////////
    // link drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        repeat (10) @(posedge rx_clk);
        rst <= 1'b0;
    endtask

    task automatic set_loss_enable(input logic ena);
        @(posedge rx_clk);
        loss_ena <= ena;
    endtask

    task automatic send_word(input logic k_msb, input logic k_lsb, input logic [RXD_W-1:0] data);
        @(posedge rx_clk);
        rkmsb <= k_msb;
        rklsb <= k_lsb;
        rxd   <= data;
    endtask

    // plain data words, never a control code
    task automatic send_idle(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            send_word(1'b0, 1'b0, r[15:0]);
        end
    endtask

    task automatic send_frame(input logic [LEN_W-1:0] len, input logic bad_head,
                              input logic bad_sum);
        logic [31:0]       r;
        logic [RXD_W-1:0]  dt_word;
        logic [RXD_W-1:0]  line_word;
        logic [RXD_W-1:0]  sum;
        logic [RXD_W-1:0]  hws [32];
        logic [WORD_W-1:0] words [8];
        logic              ovf;
        frame_info_t       rec;

        r         = $random(seed);
        dt_word   = r[15:0];
        line_word = r[31:16];
        sum       = dt_word + line_word + len;
        ovf       = 1'b0;
        for (int i = 0; i < 8; i++) begin
            words[i] = '0;
        end
        // halfword i lands at bit 16 * (i mod 4) of word i / 4, rest stays zero
        for (int i = 0; i < int'(len) / 2; i++) begin
            r      = $random(seed);
            hws[i] = r[15:0];
            sum    = sum + r[15:0];
            words[i / 4][16 * (i % 4) +: 16] = r[15:0];
        end
        // expectations go in before the frame so early handshakes find them
        if (!bad_head) begin
            for (int j = 0; j < (int'(len) + 7) / 8; j++) begin
                if (!hold_word_ready || word_room > 0) begin
                    u_checker.expect_word(words[j]);
                    word_room = hold_word_ready ? word_room - 1 : word_room;
                end else begin
                    ovf = 1'b1;
                end
            end
            rec.file_end       = dt_word[14];
            rec.channel_id     = dt_word[13:12];
            rec.data_type      = dt_word[11:8];
            rec.line_number    = {dt_word[7:0], line_word};
            rec.data_length    = len;
            rec.checksum_error = bad_sum;
            rec.overflow       = ovf;
            u_checker.expect_info(rec);
        end
        r = $random(seed);
        send_idle(int'(r[2:0]));
        send_word(1'b0, 1'b1, {D5_6, K28_5});
        send_word(1'b1, 1'b1, {K28_2, K27_7});
        send_word(1'b0, 1'b0, FRAME_HEAD_FLAG[31:16]);
        send_word(1'b0, 1'b0, FRAME_HEAD_FLAG[15:0] ^ {15'd0, bad_head});
        send_word(1'b0, 1'b0, dt_word);
        send_word(1'b0, 1'b0, line_word);
        send_word(1'b0, 1'b0, len);
        for (int i = 0; i < int'(len) / 2; i++) begin
            send_word(1'b0, 1'b0, hws[i]);
        end
        send_word(1'b0, 1'b0, sum + {15'd0, bad_sum});
        // two words for frame_end1 and frame_end2
        send_idle(2);
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (u_checker.pending() != 0 && cycles < TIMEOUT) begin
            @(posedge rx_clk);
            cycles++;
        end
        if (u_checker.pending() != 0) begin
            $display("timeout: %0d expected outputs never came out by %s",
                     u_checker.pending(), what);
            timeouts++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        apply_reset();
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            send_frame((i == 0) ? 16'd2 : {10'd0, r[4:0], 1'b0} + 16'd2,
                       (i % 7) == 5, (i % 5) == 3);
        end
        send_idle(4);

        // second loss word falls inside the hold-off window
        send_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_idle(8);
        u_checker.check_loss(1);
        send_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_idle(8);
        u_checker.check_loss(1);
        send_idle(LOSS_HOLDOFF);
        send_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_idle(8);
        u_checker.check_loss(2);
        set_loss_enable(1'b0);
        send_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_idle(8);
        u_checker.check_loss(2);
        // re-enable inside the old window, timer was cleared
        set_loss_enable(1'b1);
        send_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_idle(8);
        u_checker.check_loss(3);

        // fill the word queue from empty with ready held low
        wait_drained("the start of the overflow test");
        hold_word_ready = 1'b1;
        word_room       = WORD_DEPTH;
        repeat (3) send_frame(16'd64, 1'b0, 1'b0);
        send_idle(2);
        hold_word_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            send_frame({10'd0, r[4:0], 1'b0} + 16'd2, 1'b0, 1'b0);
        end

        wait_drained("the end of the run");
        send_idle(20);
        u_checker.report(timeouts);
        if (u_checker.error_count() == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* all.f */
source/rx_link_pkg.sv
source/rx_frame_decoder.sv
source/rx_payload_packer.sv
source/rx_link_monitor.sv
source/rx_stream_queue.sv
source/rx_link_top.sv
verification/rx_link_checker.sv
verification/tb_rx_link.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_rx_link -Mdir obj_dir &&
./obj_dir/Vtb_rx_link | tee /dev/stderr | grep -q '^\*\* PASS \*\*$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
